// File: project.f
+incdir+src
src/corr_cmd_pkg.sv
src/corr_frame_pkg.sv
src/lane_ctl_if.sv
src/cmd_parser.sv
src/pulse_lane.sv
src/frame_builder.sv
src/correlator_top.sv
bench/tb_correlator.sv

// File: Makefile
VERILATOR  := verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall
TOP        := tb_correlator
LINT_TOP   := correlator_top
FILELIST   := project.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qxF '** PASS **' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_correlator.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed-test testbench for the pulse correlator front end.
// Sends command bytes, runs windows and checks the returned frames.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "corr_config.svh"

module tb_correlator
	import corr_cmd_pkg::*;
();

	localparam int NUM = `NUM_LANES;
	localparam int FRAME_BYTES = 3 * `NUM_LANES + 2;
	localparam int TIMEOUT = 200;

	logic intclk;
	logic reset;
	logic [`NUM_LANES-1:0] line_in;
	logic [7:0] rx_byte;
	logic rx_strobe;
	logic tx_done;
	logic [7:0] tx_byte;
	logic tx_load;
	logic tx_busy;
	logic integrating;

	int value_errors;
	int other_errors;
	int lane_period [NUM];
	int lane_mode [NUM];
	logic [`COUNT_WIDTH-1:0] exp_cnt [NUM];
	logic [7:0] frame_q [$];

	correlator_top u_dut (
		.intclk(intclk),
		.reset(reset),
		.line_in(line_in),
		.rx_byte(rx_byte),
		.rx_strobe(rx_strobe),
		.tx_done(tx_done),
		.tx_byte(tx_byte),
		.tx_load(tx_load),
		.tx_busy(tx_busy),
		.integrating(integrating)
	);

	always #10 intclk = ~intclk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got == exp) else begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic next_cycle();
		@(posedge intclk);
		#1;
	endtask

	task automatic send_cmd(input logic [7:0] b0, input logic [7:0] b1, input bit two);
		rx_byte = b0;
		rx_strobe = 1'b1;
		next_cycle();
		if (two) begin
			rx_byte = b1;
			next_cycle();
		end
		rx_strobe = 1'b0;
	endtask

	task automatic configure(input int lane, input int period, input int mode);
		send_cmd({OP_SET_PERIOD, 4'(lane)}, 8'(period), 1'b1);
		send_cmd({OP_SET_MODE, 4'(lane)}, 8'(mode), 1'b1);
		if (lane < NUM) begin
			lane_period[lane] = period;
			lane_mode[lane] = mode;
		end
	endtask

	// STOP is sampled exactly n edges after START.
	task automatic run_window(input int n);
		check_value("integrating", 32'(integrating), 32'd0);
		send_cmd({OP_START, 4'h0}, 8'h00, 1'b0);
		for (int i = 1; i < n; i++) begin
			check_value("integrating", 32'(integrating), 32'd1);
			next_cycle();
		end
		check_value("integrating", 32'(integrating), 32'd1);
		send_cmd({OP_STOP, 4'h0}, 8'h00, 1'b0);
		check_value("integrating", 32'(integrating), 32'd0);
	endtask

	// ticks every period+1 cycles on the line conditioned by invert.
	function automatic int predict(input int n, input int period, input bit level,
			input bit inv, input bit edge_mode);
		int ticks;
		ticks = n / (period + 1);
		if (level == inv) begin
			return 0;
		end
		if (edge_mode) begin
			return (ticks > 0) ? 1 : 0;
		end
		return ticks;
	endfunction

	task automatic set_expected(input int n);
		for (int l = 0; l < NUM; l++) begin
			exp_cnt[l] = `COUNT_WIDTH'(predict(n, lane_period[l], line_in[l],
				lane_mode[l][0], lane_mode[l][1]));
		end
	endtask

	task automatic receive_frame(input int extra);
		int wait_cycles;
		int delay;
		bit timed_out;
		frame_q.delete();
		for (int i = 0; i < FRAME_BYTES; i++) begin
			wait_cycles = 0;
			timed_out = 1'b0;
			while (!tx_load && wait_cycles < TIMEOUT) begin
				next_cycle();
				wait_cycles++;
			end
			assert (tx_load) else begin
				$display("timed out waiting for tx_load of frame byte %0d", i);
				other_errors++;
				timed_out = 1'b1;
			end
			if (timed_out) begin
				break;
			end
			assert (wait_cycles == ((i == 0) ? 1 : 0)) else begin
				$display("frame byte %0d was not loaded on the expected cycle", i);
				other_errors++;
			end
			check_value("tx_busy", 32'(tx_busy), 32'd1);
			frame_q.push_back(tx_byte);
			delay = extra + int'($urandom_range(4, 1));
			repeat (delay) begin
				next_cycle();
				check_value("tx_load", 32'(tx_load), 32'd0);
			end
			check_value("tx_byte", 32'(tx_byte), 32'(frame_q[$]));
			tx_done = 1'b1;
			next_cycle();
			tx_done = 1'b0;
		end
		check_value("tx_busy", 32'(tx_busy), 32'd0);
	endtask

	task automatic check_frame();
		logic [7:0] exp_bytes [FRAME_BYTES];
		logic [7:0] csum;
		int k;
		exp_bytes[0] = `FRAME_SYNC;
		csum = `FRAME_SYNC;
		k = 1;
		for (int l = 0; l < NUM; l++) begin
			for (int b = 2; b >= 0; b--) begin
				exp_bytes[k] = exp_cnt[l][b*8 +: 8];
				csum = csum ^ exp_bytes[k];
				k++;
			end
		end
		exp_bytes[k] = csum;
		check_value("frame length", 32'(frame_q.size()), 32'(FRAME_BYTES));
		for (int i = 0; i < frame_q.size() && i < FRAME_BYTES; i++) begin
			check_value($sformatf("tx_byte[%0d]", i), 32'(frame_q[i]), 32'(exp_bytes[i]));
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic frame_after_reset();
		check_value("tx_load", 32'(tx_load), 32'd0);
		check_value("tx_busy", 32'(tx_busy), 32'd0);
		check_value("integrating", 32'(integrating), 32'd0);
		line_in = '0;
		run_window(25);
		set_expected(25);
		receive_frame(0);
		check_frame();
	endtask

	task automatic level_with_periods();
		for (int l = 0; l < NUM; l++) begin
			configure(l, (1 << (l % 4)) - 1, 0);
		end
		line_in = '1;
		run_window(53);
		set_expected(53);
		receive_frame(0);
		check_frame();
	endtask

	// invert on low, edge on high, both on low, plain low.
	task automatic invert_and_edge();
		for (int l = 0; l < NUM; l++) begin
			configure(l, 2, (l % 4 == 3) ? 0 : l % 4 + 1);
			line_in[l] = (l % 4 == 1);
		end
		run_window(40);
		set_expected(40);
		receive_frame(0);
		check_frame();
	endtask

	task automatic random_checksum();
		int n;
		repeat (2) begin
			for (int l = 0; l < NUM; l++) begin
				configure(l, int'($urandom_range(15, 0)), int'($urandom_range(3, 0)));
				line_in[l] = 1'($urandom_range(1, 0));
			end
			n = int'($urandom_range(120, 30));
			run_window(n);
			set_expected(n);
			receive_frame(0);
			check_frame();
		end
	endtask

	task automatic snapshot_and_stall();
		for (int l = 0; l < NUM; l++) begin
			configure(l, 0, 0);
		end
		line_in = '1;
		run_window(20);
		set_expected(20);
		fork
			receive_frame(12);
			begin
				repeat (3) begin
					next_cycle();
				end
				line_in = '0;
				run_window(10);
				check_value("tx_busy", 32'(tx_busy), 32'd1);
			end
		join
		check_frame();
		for (int i = 0; i < 40; i++) begin
			assert (!tx_load) else begin
				$display("a STOP during tx_busy started an extra frame");
				other_errors++;
			end
			next_cycle();
		end
		if (NUM < 16) begin
			configure(NUM, 5, 1);
		end
		line_in = '1;
		run_window(12);
		set_expected(12);
		receive_frame(0);
		check_frame();
	endtask

	initial begin
		void'($urandom(32'h87463143));
		value_errors = 0;
		other_errors = 0;
		for (int l = 0; l < NUM; l++) begin
			lane_period[l] = 0;
			lane_mode[l] = 0;
		end
		intclk = 1'b0;
		reset = 1'b1;
		line_in = '0;
		rx_byte = 8'h00;
		rx_strobe = 1'b0;
		tx_done = 1'b0;
		repeat (10) begin
			@(posedge intclk);
		end
		#1;
		reset = 1'b0;
		next_cycle();

		frame_after_reset();
		level_with_periods();
		invert_and_edge();
		random_checksum();
		snapshot_and_stall();

		$display("errors: %0d value mismatches, %0d protocol or timeout failures",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: src/correlator_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pulse correlator front end top level. Plain rx and tx byte strobes
// toward external serializers, one detector line per lane.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "corr_config.svh"

module correlator_top
	import corr_frame_pkg::*;
(
	input logic intclk,
	input logic reset,
	input logic [`NUM_LANES-1:0] line_in,
	input logic [7:0] rx_byte,
	input logic rx_strobe,
	input logic tx_done,
	output logic [7:0] tx_byte,
	output logic tx_load,
	output logic tx_busy,
	output logic integrating
);

	count_array_t counts;

	lane_ctl_if ctl_bus ();

	assign integrating = ctl_bus.integrating;

	cmd_parser parser (
		.intclk(intclk),
		.reset(reset),
		.rx_byte(rx_byte),
		.rx_strobe(rx_strobe),
		.ctl(ctl_bus.source)
	);

	for (genvar a = 0; a < `NUM_LANES; a++) begin : lanes_block
		pulse_lane #(.LANE_INDEX(a)) lane (
			.intclk(intclk),
			.reset(reset),
			.line(line_in[a]),
			.ctl(ctl_bus.sink),
			.count(counts[a])
		);
	end

	frame_builder builder (
		.intclk(intclk),
		.reset(reset),
		.counts(counts),
		.ctl(ctl_bus.sink),
		.tx_done(tx_done),
		.tx_byte(tx_byte),
		.tx_load(tx_load),
		.tx_busy(tx_busy)
	);

endmodule

// File: src/frame_builder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame builder. Latches the lane counts when the window closes and
// sends sync byte, counts MSB first and an XOR checksum on tx strobes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "corr_config.svh"

module frame_builder
	import corr_frame_pkg::*;
(
	input logic intclk,
	input logic reset,
	input count_array_t counts,
	lane_ctl_if.sink ctl,
	input logic tx_done,
	output logic [7:0] tx_byte,
	output logic tx_load,
	output logic tx_busy
);

	localparam int SNAP_WIDTH = `NUM_LANES * `COUNT_WIDTH;
	localparam int FRAME_BYTES = 3 * `NUM_LANES + 2;
	localparam int IDX_WIDTH = $clog2(FRAME_BYTES);

	frame_state_t state;
	logic [IDX_WIDTH-1:0] byte_idx;
	logic [SNAP_WIDTH-1:0] counts_flat;
	logic [SNAP_WIDTH-1:0] snap;
	logic [7:0] byte_reg;
	logic [7:0] csum;
	logic [7:0] snap_top;

	// lane 0 goes to the top so it shifts out first.
	always_comb begin
		for (int l = 0; l < `NUM_LANES; l++) begin
			counts_flat[(`NUM_LANES-1-l)*`COUNT_WIDTH +: `COUNT_WIDTH] = counts[l];
		end
	end

	assign snap_top = snap[SNAP_WIDTH-1 -: 8];

	assign tx_byte = byte_reg;
	assign tx_load = (state == F_SEND);
	assign tx_busy = (state != F_IDLE);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// byte sequencer.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge intclk) begin
		if (reset) begin
			state <= F_IDLE;
			byte_idx <= '0;
		end else begin
			case (state)
				F_IDLE: begin
					// a stop while a frame is out is dropped here.
					if (ctl.stop_pulse) begin
						byte_idx <= '0;
						state <= F_SEND;
					end
				end
				F_SEND: state <= F_WAIT;
				F_WAIT: begin
					if (tx_done) begin
						if (byte_idx == IDX_WIDTH'(FRAME_BYTES - 1)) begin
							state <= F_IDLE;
						end else begin
							byte_idx <= byte_idx + 1'b1;
							state <= F_SEND;
						end
					end
				end
				default: state <= F_IDLE;
			endcase
		end
	end

	always_ff @(posedge intclk) begin
		if (state == F_IDLE && ctl.stop_pulse) begin
			snap <= counts_flat;
			byte_reg <= `FRAME_SYNC;
			csum <= `FRAME_SYNC;
		end else if (state == F_WAIT && tx_done) begin
			if (byte_idx == IDX_WIDTH'(FRAME_BYTES - 2)) begin
				byte_reg <= csum;
			end else begin
				byte_reg <= snap_top;
				csum <= csum ^ snap_top;
				snap <= snap << 8;
			end
		end
	end

endmodule

// File: src/pulse_lane.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One detector lane: config register, sampling divider, edge detect and
// the pulse counter. Instantiated once per lane by the top level.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "corr_config.svh"

module pulse_lane
	import corr_cmd_pkg::*;
	import corr_frame_pkg::*;
#(
	parameter int LANE_INDEX = 0
) (
	input logic intclk,
	input logic reset,
	input logic line,
	lane_ctl_if.sink ctl,
	output count_t count
);

	lane_cfg_t cfg;
	logic [`PERIOD_WIDTH-1:0] div;
	logic prev_sample;

	logic [`PERIOD_WIDTH-1:0] div_cur;
	count_t count_cur;
	logic prev_cur;
	logic sample;
	logic tick;
	logic hit;

	// a start pulse is also the first cycle of the window.
	assign div_cur = ctl.start_pulse ? '0 : div;
	assign count_cur = ctl.start_pulse ? '0 : count;
	assign prev_cur = ctl.start_pulse ? 1'b0 : prev_sample;

	assign sample = line ^ cfg.invert;
	assign tick = ctl.integrating && (div_cur == cfg.period);
	assign hit = cfg.edge_mode ? (sample && !prev_cur) : sample;

	always_ff @(posedge intclk) begin
		if (reset) begin
			cfg <= '0;
		end else if (ctl.cfg_write && ctl.cfg_lane == 4'(LANE_INDEX)) begin
			cfg <= ctl.cfg_data;
		end
	end

	always_ff @(posedge intclk) begin
		if (reset) begin
			div <= '0;
			prev_sample <= 1'b0;
			count <= '0;
		end else if (ctl.integrating) begin
			div <= tick ? '0 : div_cur + 1'b1;
			prev_sample <= tick ? sample : prev_cur;
			// wraps at the counter width.
			count <= (tick && hit) ? count_cur + 1'b1 : count_cur;
		end
	end

endmodule

// File: src/cmd_parser.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte command decoder. Turns strobed rx bytes into lane configuration
// writes and the start and stop of the integration window.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "corr_config.svh"

module cmd_parser
	import corr_cmd_pkg::*;
(
	input logic intclk,
	input logic reset,
	input logic [7:0] rx_byte,
	input logic rx_strobe,
	lane_ctl_if.source ctl
);

	parser_state_t state;
	opcode_t rx_op;
	opcode_t pend_op;
	logic [3:0] pend_lane;
	// copy of every addressable lane config, so a SET keeps the other fields.
	lane_cfg_t shadow [16];
	lane_cfg_t arg_cfg;

	assign rx_op = opcode_t'(rx_byte[7:4]);

	always_comb begin
		arg_cfg = shadow[pend_lane];
		if (pend_op == OP_SET_PERIOD) begin
			arg_cfg.period = rx_byte[`PERIOD_WIDTH-1:0];
		end else begin
			arg_cfg.invert = rx_byte[0];
			arg_cfg.edge_mode = rx_byte[1];
		end
	end

	always_ff @(posedge intclk) begin
		if (reset) begin
			state <= P_IDLE;
			pend_op <= OP_SET_PERIOD;
			pend_lane <= '0;
			ctl.cfg_write <= 1'b0;
			ctl.start_pulse <= 1'b0;
			ctl.stop_pulse <= 1'b0;
			ctl.integrating <= 1'b0;
			for (int i = 0; i < 16; i++) begin
				shadow[i] <= '0;
			end
		end else begin
			ctl.cfg_write <= 1'b0;
			ctl.start_pulse <= 1'b0;
			ctl.stop_pulse <= 1'b0;
			if (rx_strobe) begin
				case (state)
					P_IDLE: begin
						case (rx_op)
							OP_START: begin
								if (!ctl.integrating) begin
									ctl.start_pulse <= 1'b1;
									ctl.integrating <= 1'b1;
								end
							end
							OP_STOP: begin
								if (ctl.integrating) begin
									ctl.stop_pulse <= 1'b1;
									ctl.integrating <= 1'b0;
								end
							end
							OP_SET_PERIOD, OP_SET_MODE: begin
								pend_op <= rx_op;
								pend_lane <= rx_byte[3:0];
								state <= P_ARG;
							end
							default: ;
						endcase
					end
					P_ARG: begin
						shadow[pend_lane] <= arg_cfg;
						ctl.cfg_lane <= pend_lane;
						ctl.cfg_data <= arg_cfg;
						ctl.cfg_write <= 1'b1;
						state <= P_IDLE;
					end
					default: state <= P_IDLE;
				endcase
			end
		end
	end

endmodule

// File: src/lane_ctl_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lane control bus from the command parser to the lanes and builder.
// The parser holds the source side, every consumer the sink side.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

interface lane_ctl_if
	import corr_cmd_pkg::*;
();

	logic [3:0] cfg_lane;
	lane_cfg_t cfg_data;
	logic cfg_write;
	logic start_pulse;
	logic stop_pulse;
	// high for the whole integration window.
	logic integrating;

	modport source (
		output cfg_lane, cfg_data, cfg_write,
		output start_pulse, stop_pulse, integrating
	);

	modport sink (
		input cfg_lane, cfg_data, cfg_write,
		input start_pulse, stop_pulse, integrating
	);

endinterface

// File: src/corr_frame_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame side types: lane counts and the frame builder states.
// Imported by the lanes, the frame builder and the top level.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "corr_config.svh"

package corr_frame_pkg;

	typedef logic [`COUNT_WIDTH-1:0] count_t;

	// lane 0 sits at index 0.
	typedef count_t [`NUM_LANES-1:0] count_array_t;

	typedef enum logic [1:0] {
		F_IDLE,
		F_SEND,
		F_WAIT
	} frame_state_t;

endpackage

// File: src/corr_cmd_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command side types: opcodes, parser states and lane configuration.
// Imported by the parser, the control interface and the lanes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "corr_config.svh"

package corr_cmd_pkg;

	// high nibble of a command byte.
	typedef enum logic [3:0] {
		OP_SET_PERIOD = 4'd1,
		OP_SET_MODE   = 4'd2,
		OP_START      = 4'd3,
		OP_STOP       = 4'd4
	} opcode_t;

	typedef enum logic {P_IDLE, P_ARG} parser_state_t;

	typedef struct packed {
		logic [`PERIOD_WIDTH-1:0] period;
		logic invert;
		logic edge_mode;
	} lane_cfg_t;

endpackage

// File: src/corr_config.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Build-time sizes of the pulse correlator front end.
// Included by the packages and by any module that sizes its ports.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CORR_CONFIG_SVH
`define CORR_CONFIG_SVH

// up to 16 detector lanes.
`define NUM_LANES 4
// three frame bytes per lane count.
`define COUNT_WIDTH 24
`define PERIOD_WIDTH 8
`define FRAME_SYNC 8'hA5

`endif
